// File: compile.f
src/kcpu_isa_pkg.sv
src/kcpu_uc_pkg.sv
src/kcpu_ucode_if.sv
src/kcpu_ucode.sv
src/kcpu_branch.sv
src/kcpu_pshpul.sv
src/kcpu_ctrl.sv
src/kcpu_ctrl_top.sv
sim/kcpu_ctrl_assert.sv
sim/kcpu_ctrl_checker.sv
sim/tb_kcpu_ctrl.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the kcpu control testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -j 0 -f compile.f --top-module tb_kcpu_ctrl -o sim_kcpu

# keep running past assertion errors so the testbench can count them
./obj_dir/sim_kcpu +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

// File: sim/kcpu_ctrl_assert.sv
////////////////////////////////////////
// kcpu control protocol assertions
// bound to the top level
////////////////////////////////////////

module kcpu_ctrl_assert (
    input  logic       clk,
    input  logic       rst,
    input  logic       op_valid,
    input  logic       busy,
    input  logic       done,
    input  logic [7:0] psh_sel,
    input  logic       wrq,
    input  logic       pul_en
);

    int failures = 0;

    // the source may only strobe while the section is idle
    no_op_while_busy: assert property (@(posedge clk) disable iff (rst) op_valid |-> !busy)
        else begin
            $error("op_valid strobed while busy");
            failures++;
        end

    sel_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(psh_sel))
        else begin
            $error("psh_sel has more than one bit set");
            failures++;
        end

    no_read_write: assert property (@(posedge clk) disable iff (rst) !(wrq && pul_en))
        else begin
            $error("wrq and pul_en high together");
            failures++;
        end

    done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $error("done held high for more than one cycle");
            failures++;
        end

endmodule

bind kcpu_ctrl_top kcpu_ctrl_assert u_assert (
    .clk      ( clk      ),
    .rst      ( rst      ),
    .op_valid ( op_valid ),
    .busy     ( busy     ),
    .done     ( done     ),
    .psh_sel  ( psh_sel  ),
    .wrq      ( wrq      ),
    .pul_en   ( pul_en   )
);

// File: sim/kcpu_ctrl_checker.sv
////////////////////////////////////////
// kcpu control reference checker
// keeps its own pc and sp and compares
// every stack byte and every done
////////////////////////////////////////

module kcpu_ctrl_checker #(
    parameter logic [15:0] PC_RESET = 16'h0000,
    parameter logic [15:0] SP_RESET = 16'h0200
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        op_valid,
    input  logic [7:0]  op,
    input  logic [15:0] data,
    input  logic [7:0]  cc,
    input  logic [4:0]  lat,
    input  logic [15:0] pc,
    input  logic [15:0] sp,
    input  logic [2:0]  up,
    input  logic [7:0]  psh_sel,
    input  logic        hi_lon,
    input  logic        wrq,
    input  logic        pul_en,
    input  logic        busy,
    input  logic        done,
    output int          errors
);

    int          count = 0;
    int          cyc;
    logic        running, push;
    logic [4:0]  want_lat;
    logic [2:0]  want_up;
    logic [15:0] model_pc, model_sp, want_pc;
    // one entry per stack byte {hi_lon, psh_sel, sp}
    logic [24:0] bytes[$];

    assign errors = count;

    task automatic fail_value(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
        count++;
    endtask

    task automatic fail_event(input string what);
        $display("Error at %0t: %s", $time, what);
        count++;
    endtask

    // C is flag bit 0, Z bit 2, N bit 3
    function automatic logic [15:0] new_pc(input logic [7:0] o, input logic [15:0] d,
                                           input logic [7:0] f, input logic [15:0] p);
        logic take;
        take = 1'b0;
        case (o)
            kcpu_isa_pkg::OP_JMP:  return d;
            kcpu_isa_pkg::OP_LBRA: return p + 16'd3 + d;
            kcpu_isa_pkg::OP_LDX:  return p + 16'd3;
            kcpu_isa_pkg::OP_LDA, kcpu_isa_pkg::OP_LDB,
            kcpu_isa_pkg::OP_PSHS, kcpu_isa_pkg::OP_PULS: return p + 16'd2;
            kcpu_isa_pkg::OP_BRA:  take = 1'b1;
            kcpu_isa_pkg::OP_BCC:  take = !f[0];
            kcpu_isa_pkg::OP_BCS:  take = f[0];
            kcpu_isa_pkg::OP_BNE:  take = !f[2];
            kcpu_isa_pkg::OP_BEQ:  take = f[2];
            kcpu_isa_pkg::OP_BPL:  take = !f[3];
            kcpu_isa_pkg::OP_BMI:  take = f[3];
            default:               return p + 16'd1;
        endcase
        return take ? p + 16'd2 + {{8{d[7]}}, d[7:0]} : p + 16'd2;
    endfunction

    always @(negedge clk) begin
        logic [24:0] e;
        logic [15:0] s;
        logic        hi;
        int          b;
        if (rst) begin
            model_pc = PC_RESET;
            model_sp = SP_RESET;
            running  = 1'b0;
            cyc      = 0;
            bytes.delete();
        end else begin
            if (running) cyc++;
            if (busy !== running) fail_value("busy", {15'd0, busy}, {15'd0, running});
            if (wrq || pul_en) begin
                if (bytes.size() == 0) begin
                    fail_event("stack byte strobe with no byte left to send");
                end else begin
                    e = bytes.pop_front();
                    if (psh_sel !== e[23:16]) fail_value("psh_sel", {8'h00, psh_sel},
                                                         {8'h00, e[23:16]});
                    if (hi_lon !== e[24]) fail_value("hi_lon", {15'd0, hi_lon}, {15'd0, e[24]});
                    if (sp !== e[15:0]) fail_value("sp", sp, e[15:0]);
                    if (wrq !== push) fail_value("wrq", {15'd0, wrq}, {15'd0, push});
                    if (pul_en !== ~push) begin
                        fail_value("pul_en", {15'd0, pul_en}, {15'd0, ~push});
                    end
                    model_sp = push ? e[15:0] : e[15:0] + 16'd1;
                end
            end else begin
                if (psh_sel !== 8'h00) fail_value("psh_sel", {8'h00, psh_sel}, 16'h0000);
                if (sp !== model_sp) fail_value("sp", sp, model_sp);
            end
            if (done && running) begin
                if (cyc != int'(want_lat)) begin
                    fail_event($sformatf("done came %0d cycles after op_valid, not %0d",
                                         cyc, want_lat));
                end
                if (bytes.size() != 0) fail_event("done came before the last stack byte");
                if (pc !== want_pc) fail_value("pc", pc, want_pc);
                if (up !== want_up) fail_value("up_a/up_b/up_x", {13'd0, up}, {13'd0, want_up});
                model_pc = want_pc;
                running  = 1'b0;
            end else begin
                if (done) fail_event("done with no instruction running");
                if (pc !== model_pc) fail_value("pc", pc, model_pc);
                if (up !== 3'b000) fail_value("up_a/up_b/up_x", {13'd0, up}, 16'h0000);
            end
            if (op_valid) begin
                want_pc  = new_pc(op, data, cc, model_pc);
                want_up  = {op == kcpu_isa_pkg::OP_LDA, op == kcpu_isa_pkg::OP_LDB,
                            op == kcpu_isa_pkg::OP_LDX};
                want_lat = lat;
                push     = op == kcpu_isa_pkg::OP_PSHS;
                s        = model_sp;
                if (push || op == kcpu_isa_pkg::OP_PULS) begin
                    for (int i = 0; i < 8; i++) begin
                        b = push ? 7 - i : i;
                        if (data[b]) begin
                            for (int h = 0; h < ((b >= 4) ? 2 : 1); h++) begin
                                // push sends low then high, pull high then low
                                hi = (b >= 4) && (push ? (h == 1) : (h == 0));
                                if (push) s = s - 16'd1;
                                bytes.push_back({hi, 8'b1 << b, s});
                                if (!push) s = s + 16'd1;
                            end
                        end
                    end
                end
                running = 1'b1;
                cyc     = 0;
            end
        end
    end

endmodule

// File: sim/tb_kcpu_ctrl.sv
////////////////////////////////////////
// kcpu control section testbench
// directed table, random mix, watchdog
////////////////////////////////////////

module tb_kcpu_ctrl;

    localparam logic [15:0] PC_RESET   = 16'h0000;
    localparam logic [15:0] SP_RESET   = 16'h0200;
    localparam int          CLK_PERIOD = 8;
    localparam int          RST_CYCLES = 16;
    localparam int          NUM_DIR    = 29;
    localparam int          NUM_RND    = 40;
    localparam int          DONE_LIMIT = 20;

    logic        clk, rst, op_valid;
    logic [7:0]  op, cc;
    logic [15:0] data;
    logic [4:0]  lat;
    logic [15:0] pc, sp;
    logic        up_a, up_b, up_x, hi_lon, wrq, pul_en, busy, done;
    logic [7:0]  psh_sel;
    int          chk_errors;
    int          tb_errors;
    integer      seed;

    // table columns are op, data, cc and cycles from op_valid to done
    logic [7:0]  t_op[$];
    logic [15:0] t_data[$];
    logic [7:0]  t_cc[$];
    logic [4:0]  t_lat[$];

    kcpu_ctrl_top #(
        .PC_RESET ( PC_RESET ),
        .SP_RESET ( SP_RESET )
    ) dut (
        .clk ( clk ), .rst ( rst ), .op_valid ( op_valid ), .op ( op ),
        .data ( data ), .cc ( cc ), .pc ( pc ), .sp ( sp ),
        .up_a ( up_a ), .up_b ( up_b ), .up_x ( up_x ), .psh_sel ( psh_sel ),
        .hi_lon ( hi_lon ), .wrq ( wrq ), .pul_en ( pul_en ),
        .busy ( busy ), .done ( done )
    );

    kcpu_ctrl_checker #(
        .PC_RESET ( PC_RESET ),
        .SP_RESET ( SP_RESET )
    ) u_checker (
        .clk ( clk ), .rst ( rst ), .op_valid ( op_valid ), .op ( op ),
        .data ( data ), .cc ( cc ), .lat ( lat ), .pc ( pc ), .sp ( sp ),
        .up ( {up_a, up_b, up_x} ), .psh_sel ( psh_sel ), .hi_lon ( hi_lon ),
        .wrq ( wrq ), .pul_en ( pul_en ), .busy ( busy ), .done ( done ),
        .errors ( chk_errors )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic add_entry(input logic [7:0] o, input logic [15:0] d,
                             input logic [7:0] f, input logic [4:0] n);
        t_op.push_back(o);
        t_data.push_back(d);
        t_cc.push_back(f);
        t_lat.push_back(n);
    endtask

    // one cycle to done, plus one cycle per stack byte
    function automatic logic [4:0] stack_cycles(input logic [7:0] o, input logic [15:0] d);
        logic [4:0] n;
        n = 5'd1;
        if (o == 8'h34 || o == 8'h35) begin
            for (int i = 0; i < 8; i++) begin
                if (d[i]) n = n + ((i >= 4) ? 5'd2 : 5'd1);
            end
        end
        return n;
    endfunction

    task automatic issue(input logic [7:0] o, input logic [15:0] d,
                         input logic [7:0] f, input logic [4:0] n);
        int   waited;
        logic seen;
        op       = o;
        data     = d;
        cc       = f;
        lat      = n;
        op_valid = 1'b1;
        @(posedge clk);
        #1 op_valid = 1'b0;
        // op and data are only valid together with the strobe
        op   = ~o;
        data = ~d;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < DONE_LIMIT) begin
            @(negedge clk);
            seen = done;
            waited++;
        end
        if (!seen) begin
            $display("Error at %0t: no done within %0d cycles for op %h", $time, DONE_LIMIT, o);
            tb_errors++;
        end
        // next instruction goes out in the first idle cycle
        @(posedge clk);
        #1;
    endtask

    initial begin
        #((RST_CYCLES + (NUM_DIR + NUM_RND) * DONE_LIMIT) * CLK_PERIOD);
        $display("Error: run did not finish in time, a done is missing");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        logic [7:0]  pick[16];
        logic [31:0] r;
        logic [7:0]  o;
        logic [15:0] d;
        tb_errors = 0;
        seed      = 32'hc59091e7;
        rst       = 1'b1;
        op_valid  = 1'b0;
        op        = 8'h12;
        data      = 16'h0000;
        cc        = 8'h00;
        lat       = 5'd1;
        pick      = '{8'h12, 8'h86, 8'hC6, 8'h8E, 8'h20, 8'h24, 8'h25, 8'h26,
                      8'h27, 8'h2A, 8'h2B, 8'h16, 8'h7E, 8'h34, 8'h35, 8'h01};

        add_entry(8'h12, 16'h0000, 8'h00, 5'd1);
        add_entry(8'h86, 16'h0055, 8'h00, 5'd1);
        add_entry(8'hC6, 16'h00AA, 8'h0F, 5'd1);
        add_entry(8'h8E, 16'h1234, 8'h00, 5'd1);
        add_entry(8'h01, 16'h0000, 8'h00, 5'd1);
        add_entry(8'hFF, 16'hFFFF, 8'h00, 5'd1);
        add_entry(8'h20, 16'h0010, 8'h00, 5'd1);
        add_entry(8'h20, 16'hAAFA, 8'h00, 5'd1);
        add_entry(8'h27, 16'h00F0, 8'h04, 5'd1);
        add_entry(8'h27, 16'h0040, 8'h00, 5'd1);
        add_entry(8'h26, 16'h0020, 8'h00, 5'd1);
        add_entry(8'h26, 16'h0020, 8'h04, 5'd1);
        add_entry(8'h25, 16'h0080, 8'h01, 5'd1);
        add_entry(8'h25, 16'h0080, 8'h00, 5'd1);
        add_entry(8'h24, 16'h0030, 8'h00, 5'd1);
        add_entry(8'h24, 16'h0030, 8'h01, 5'd1);
        add_entry(8'h2A, 16'h00E0, 8'h00, 5'd1);
        add_entry(8'h2A, 16'h00E0, 8'h08, 5'd1);
        add_entry(8'h2B, 16'h0011, 8'h08, 5'd1);
        add_entry(8'h2B, 16'h0011, 8'h00, 5'd1);
        add_entry(8'h16, 16'h0100, 8'h0F, 5'd1);
        add_entry(8'h16, 16'hFF00, 8'h00, 5'd1);
        add_entry(8'h7E, 16'h4000, 8'h00, 5'd1);
        add_entry(8'h34, 16'h00FF, 8'h00, 5'd13);
        add_entry(8'h34, 16'h0081, 8'h00, 5'd4);
        add_entry(8'h34, 16'h0000, 8'h00, 5'd1);
        add_entry(8'h35, 16'h0000, 8'h00, 5'd1);
        add_entry(8'h35, 16'h0081, 8'h00, 5'd4);
        add_entry(8'h35, 16'h00FF, 8'h00, 5'd13);

        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        @(posedge clk);
        #1;
        for (int i = 0; i < t_op.size(); i++) begin
            issue(t_op[i], t_data[i], t_cc[i], t_lat[i]);
        end

        for (int i = 0; i < NUM_RND; i++) begin
            r = $random(seed);
            o = pick[r[3:0]];
            r = $random(seed);
            d = r[15:0];
            issue(o, d, r[23:16], stack_cycles(o, d));
        end

        @(posedge clk);
        #1;
        $display("errors: checker %0d, testbench %0d, assertions %0d",
                 chk_errors, tb_errors, dut.u_assert.failures);
        if (chk_errors + tb_errors + dut.u_assert.failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: src/kcpu_branch.sv
////////////////////////////////////////
// kcpu branch condition evaluator
// checks the opcode against the flags
////////////////////////////////////////

module kcpu_branch (
    input  kcpu_isa_pkg::op_e op,
    input  logic [7:0]        cc,
    output logic              branch
);

    logic flag_c, flag_z, flag_n;

    assign flag_c = cc[kcpu_isa_pkg::CC_C];
    assign flag_z = cc[kcpu_isa_pkg::CC_Z];
    assign flag_n = cc[kcpu_isa_pkg::CC_N];

    always_comb begin
        case (op)
            kcpu_isa_pkg::OP_BRA,
            kcpu_isa_pkg::OP_LBRA,
            kcpu_isa_pkg::OP_JMP: branch = 1'b1;
            kcpu_isa_pkg::OP_BCC: branch = !flag_c;
            kcpu_isa_pkg::OP_BCS: branch = flag_c;
            kcpu_isa_pkg::OP_BNE: branch = !flag_z;
            kcpu_isa_pkg::OP_BEQ: branch = flag_z;
            kcpu_isa_pkg::OP_BPL: branch = !flag_n;
            kcpu_isa_pkg::OP_BMI: branch = flag_n;
            default:              branch = 1'b0;
        endcase
    end

endmodule

// File: src/kcpu_ctrl.sv
////////////////////////////////////////
// kcpu control section
// instruction register, pc update and
// register load strobes
////////////////////////////////////////

module kcpu_ctrl #(
    parameter logic [15:0] PC_RESET = 16'h0000,
    parameter logic [15:0] SP_RESET = 16'h0200
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        op_valid,
    input  logic [7:0]  op,
    input  logic [15:0] data,
    input  logic [7:0]  cc,
    output logic [15:0] pc,
    output logic [15:0] sp,
    output logic        up_a,
    output logic        up_b,
    output logic        up_x,
    output logic [7:0]  psh_sel,
    output logic        hi_lon,
    output logic        wrq,
    output logic        pul_en,
    output logic        busy,
    output logic        done
);

    kcpu_ucode_if uc_if ();

    kcpu_isa_pkg::op_e ir_op;
    logic [15:0]       ir_data;
    logic [15:0]       pc_q, pc_next;
    logic [1:0]        len;
    logic              branch;

    always_ff @(posedge clk) begin
        if (op_valid) begin
            ir_op   <= kcpu_isa_pkg::op_e'(op);
            ir_data <= data;
        end
    end

    assign len = kcpu_isa_pkg::op_len(ir_op);

    // decisions only show up in the finishing cycle, pc holds otherwise
    always_comb begin
        pc_next = pc_q;
        if (uc_if.set_pc_jmp) begin
            pc_next = ir_data;
        end else if (uc_if.set_pc_branch16 && branch) begin
            pc_next = pc_q + {14'd0, len} + ir_data;
        end else if (uc_if.set_pc_branch8 && branch) begin
            pc_next = pc_q + {14'd0, len} + {{8{ir_data[7]}}, ir_data[7:0]};
        end else if (uc_if.ni) begin
            pc_next = pc_q + {14'd0, len};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= PC_RESET;
        end else begin
            pc_q <= pc_next;
        end
    end

    // new pc is visible from the finishing cycle on
    assign pc = pc_next;

    // LDA 86 and LDB C6 differ in bit 6, LDX is 8E
    assign up_a = uc_if.up_ld8 && !ir_op[6];
    assign up_b = uc_if.up_ld8 &&  ir_op[6];
    assign up_x = uc_if.up_ld16 && ir_op[3:1] == 3'b111;

    kcpu_ucode u_ucode (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .op_valid ( op_valid ),
        .op       ( op       ),
        .uc       ( uc_if    ),
        .busy     ( busy     ),
        .done     ( done     )
    );

    kcpu_branch u_branch (
        .op     ( ir_op  ),
        .cc     ( cc     ),
        .branch ( branch )
    );

    // postbyte comes straight from the operand as the walk starts at op_valid
    kcpu_pshpul #(
        .SP_RESET ( SP_RESET )
    ) u_pshpul (
        .clk      ( clk       ),
        .rst      ( rst       ),
        .postdata ( data[7:0] ),
        .st       ( uc_if     ),
        .psh_sel  ( psh_sel   ),
        .hi_lon   ( hi_lon    ),
        .wrq      ( wrq       ),
        .pul_en   ( pul_en    ),
        .sp       ( sp        )
    );

endmodule

// File: src/kcpu_ctrl_top.sv
////////////////////////////////////////
// kcpu control section top level
// sets the reset addresses
////////////////////////////////////////

module kcpu_ctrl_top #(
    parameter logic [15:0] PC_RESET = 16'h0000,
    parameter logic [15:0] SP_RESET = 16'h0200
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        op_valid,
    input  logic [7:0]  op,
    input  logic [15:0] data,
    input  logic [7:0]  cc,
    output logic [15:0] pc,
    output logic [15:0] sp,
    output logic        up_a,
    output logic        up_b,
    output logic        up_x,
    output logic [7:0]  psh_sel,
    output logic        hi_lon,
    output logic        wrq,
    output logic        pul_en,
    output logic        busy,
    output logic        done
);

    kcpu_ctrl #(
        .PC_RESET ( PC_RESET ),
        .SP_RESET ( SP_RESET )
    ) u_ctrl (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .op_valid ( op_valid ),
        .op       ( op       ),
        .data     ( data     ),
        .cc       ( cc       ),
        .pc       ( pc       ),
        .sp       ( sp       ),
        .up_a     ( up_a     ),
        .up_b     ( up_b     ),
        .up_x     ( up_x     ),
        .psh_sel  ( psh_sel  ),
        .hi_lon   ( hi_lon   ),
        .wrq      ( wrq      ),
        .pul_en   ( pul_en   ),
        .busy     ( busy     ),
        .done     ( done     )
    );

endmodule

// File: src/kcpu_isa_pkg.sv
////////////////////////////////////////
// kcpu instruction set definitions
// opcodes, flag bits, stack postbyte map
// and instruction lengths
////////////////////////////////////////

package kcpu_isa_pkg;

    // reduced 6809 opcode set
    typedef enum logic [7:0] {
        OP_NOP  = 8'h12,
        OP_LBRA = 8'h16,
        OP_BRA  = 8'h20,
        OP_BCC  = 8'h24,
        OP_BCS  = 8'h25,
        OP_BNE  = 8'h26,
        OP_BEQ  = 8'h27,
        OP_BPL  = 8'h2A,
        OP_BMI  = 8'h2B,
        OP_PSHS = 8'h34,
        OP_PULS = 8'h35,
        OP_JMP  = 8'h7E,
        OP_LDA  = 8'h86,
        OP_LDX  = 8'h8E,
        OP_LDB  = 8'hC6
    } op_e;

    // condition code bit positions
    localparam int unsigned CC_C = 0;
    localparam int unsigned CC_V = 1;
    localparam int unsigned CC_Z = 2;
    localparam int unsigned CC_N = 3;

    // postbyte map, bits 0..3 are 8-bit registers, 4..7 are 16-bit
    localparam int unsigned PB_CC = 0;
    localparam int unsigned PB_A  = 1;
    localparam int unsigned PB_B  = 2;
    localparam int unsigned PB_DP = 3;
    localparam int unsigned PB_X  = 4;
    localparam int unsigned PB_Y  = 5;
    localparam int unsigned PB_U  = 6;
    localparam int unsigned PB_PC = 7;

    // instruction length in bytes, unknown opcodes count as one
    function automatic logic [1:0] op_len(input logic [7:0] op);
        case (op)
            OP_LDA, OP_LDB,
            OP_BRA, OP_BCC, OP_BCS, OP_BNE, OP_BEQ, OP_BPL, OP_BMI,
            OP_PSHS, OP_PULS:          return 2'd2;
            OP_LDX, OP_LBRA, OP_JMP:   return 2'd3;
            default:                   return 2'd1;
        endcase
    endfunction

endpackage

// File: src/kcpu_pshpul.sv
////////////////////////////////////////
// kcpu push/pull sequencer
// walks the postbyte one stack byte per
// cycle and keeps the stack pointer
////////////////////////////////////////

module kcpu_pshpul #(
    parameter logic [15:0] SP_RESET = 16'h0200
) (
    input  logic         clk,
    input  logic         rst,
    input  logic [7:0]   postdata,
    kcpu_ucode_if.pshpul st,
    output logic [7:0]   psh_sel,
    output logic         hi_lon,
    output logic         wrq,
    output logic         pul_en,
    output logic [15:0]  sp
);

    kcpu_uc_pkg::stk_mask_t pend, sel, rest;
    kcpu_uc_pkg::stk_dir_e  dir;

    logic        half;
    logic        active, is_push, is16, reg_end, last;
    logic [15:0] sp_q;

    // push takes the highest pending bit, pull the lowest
    always_comb begin
        sel = '0;
        if (dir == kcpu_uc_pkg::STK_PUSH) begin
            for (int i = 0; i < 8; i++) begin
                if (pend[i]) begin
                    sel    = '0;
                    sel[i] = 1'b1;
                end
            end
        end else begin
            for (int i = 7; i >= 0; i--) begin
                if (pend[i]) begin
                    sel    = '0;
                    sel[i] = 1'b1;
                end
            end
        end
    end

    assign active  = |pend;
    assign is_push = dir == kcpu_uc_pkg::STK_PUSH;
    assign is16    = |sel[kcpu_isa_pkg::PB_PC:kcpu_isa_pkg::PB_X];
    assign reg_end = !is16 || half;
    assign rest    = pend & ~sel;
    assign last    = active && reg_end && rest == '0;

    // push sends low then high, pull sends high then low
    assign hi_lon  = is16 && (is_push ? half : !half);
    assign psh_sel = sel;
    assign wrq     = active && is_push;
    assign pul_en  = active && !is_push;

    // predecrement on push so the byte goes below the old top
    assign sp = (active && is_push) ? sp_q - 16'd1 : sp_q;

    assign st.stk_done = last || (st.stk_go && postdata == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            pend <= '0;
            half <= 1'b0;
            dir  <= kcpu_uc_pkg::STK_PUSH;
            sp_q <= SP_RESET;
        end else if (st.stk_go) begin
            pend <= postdata;
            half <= 1'b0;
            dir  <= st.stk_dir;
        end else if (active) begin
            if (reg_end) begin
                pend <= rest;
                half <= 1'b0;
            end else begin
                half <= 1'b1;
            end
            sp_q <= is_push ? sp_q - 16'd1 : sp_q + 16'd1;
        end
    end

endmodule

// File: src/kcpu_uc_pkg.sv
////////////////////////////////////////
// kcpu microcode sequencer types
// states and stack walk definitions
////////////////////////////////////////

package kcpu_uc_pkg;

    // sequencer states
    typedef enum logic [1:0] {
        UC_IDLE,
        UC_EXEC,
        UC_STACK,
        UC_FINISH
    } uc_state_e;

    // stack walk direction
    typedef enum logic {
        STK_PUSH,
        STK_PULL
    } stk_dir_e;

    // one bit per register named in the postbyte
    typedef logic [7:0] stk_mask_t;

endpackage

// File: src/kcpu_ucode.sv
////////////////////////////////////////
// kcpu microcode sequencer
// decodes the opcode at op_valid and
// steps through exec, stack and finish
////////////////////////////////////////

module kcpu_ucode (
    input  logic        clk,
    input  logic        rst,
    input  logic        op_valid,
    input  logic [7:0]  op,
    kcpu_ucode_if.ucode uc,
    output logic        busy,
    output logic        done
);

    kcpu_uc_pkg::uc_state_e state, state_nx;

    logic start, is_stack, fin;
    // decode of the incoming opcode
    logic d_ni, d_br8, d_br16, d_jmp, d_ld8, d_ld16;
    // decisions held until the finishing cycle
    logic q_ni, q_br8, q_br16, q_jmp, q_ld8, q_ld16;

    assign start = op_valid && state == kcpu_uc_pkg::UC_IDLE;

    always_comb begin
        d_ni     = 1'b0;
        d_br8    = 1'b0;
        d_br16   = 1'b0;
        d_jmp    = 1'b0;
        d_ld8    = 1'b0;
        d_ld16   = 1'b0;
        is_stack = 1'b0;
        case (op)
            kcpu_isa_pkg::OP_LDA, kcpu_isa_pkg::OP_LDB: begin
                d_ld8 = 1'b1;
                d_ni  = 1'b1;
            end
            kcpu_isa_pkg::OP_LDX: begin
                d_ld16 = 1'b1;
                d_ni   = 1'b1;
            end
            kcpu_isa_pkg::OP_BRA, kcpu_isa_pkg::OP_BCC, kcpu_isa_pkg::OP_BCS,
            kcpu_isa_pkg::OP_BNE, kcpu_isa_pkg::OP_BEQ, kcpu_isa_pkg::OP_BPL,
            kcpu_isa_pkg::OP_BMI: begin
                // not taken falls back to ni
                d_br8 = 1'b1;
                d_ni  = 1'b1;
            end
            kcpu_isa_pkg::OP_LBRA: d_br16 = 1'b1;
            kcpu_isa_pkg::OP_JMP:  d_jmp  = 1'b1;
            kcpu_isa_pkg::OP_PSHS, kcpu_isa_pkg::OP_PULS: begin
                is_stack = 1'b1;
                d_ni     = 1'b1;
            end
            // NOP and anything unknown
            default: d_ni = 1'b1;
        endcase
    end

    // the stack walk starts in the same cycle as op_valid
    assign uc.stk_go  = start && is_stack;
    assign uc.stk_dir = (op == kcpu_isa_pkg::OP_PULS) ? kcpu_uc_pkg::STK_PULL
                                                      : kcpu_uc_pkg::STK_PUSH;

    always_comb begin
        state_nx = state;
        case (state)
            kcpu_uc_pkg::UC_IDLE: begin
                if (start) begin
                    if (!is_stack) begin
                        state_nx = kcpu_uc_pkg::UC_EXEC;
                    end else if (uc.stk_done) begin
                        // empty postbyte
                        state_nx = kcpu_uc_pkg::UC_FINISH;
                    end else begin
                        state_nx = kcpu_uc_pkg::UC_STACK;
                    end
                end
            end
            kcpu_uc_pkg::UC_STACK: begin
                if (uc.stk_done) begin
                    state_nx = kcpu_uc_pkg::UC_FINISH;
                end
            end
            default: state_nx = kcpu_uc_pkg::UC_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= kcpu_uc_pkg::UC_IDLE;
        end else begin
            state <= state_nx;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            q_ni   <= d_ni;
            q_br8  <= d_br8;
            q_br16 <= d_br16;
            q_jmp  <= d_jmp;
            q_ld8  <= d_ld8;
            q_ld16 <= d_ld16;
        end
    end

    assign fin = state == kcpu_uc_pkg::UC_EXEC || state == kcpu_uc_pkg::UC_FINISH;

    assign uc.ni              = fin && q_ni;
    assign uc.set_pc_branch8  = fin && q_br8;
    assign uc.set_pc_branch16 = fin && q_br16;
    assign uc.set_pc_jmp      = fin && q_jmp;
    assign uc.up_ld8          = fin && q_ld8;
    assign uc.up_ld16         = fin && q_ld16;

    assign busy = state != kcpu_uc_pkg::UC_IDLE;
    assign done = fin;

endmodule

// File: src/kcpu_ucode_if.sv
////////////////////////////////////////
// kcpu microcode decision bundle
// sequencer to control and stack walker
////////////////////////////////////////

interface kcpu_ucode_if;

    // pc decisions, only valid in the finishing cycle
    logic ni;
    logic set_pc_branch8;
    logic set_pc_branch16;
    logic set_pc_jmp;

    // register loads before decoding the target
    logic up_ld8;
    logic up_ld16;

    // stack walk control
    logic                   stk_go;
    kcpu_uc_pkg::stk_dir_e  stk_dir;
    logic                   stk_done;

    modport ucode (
        output ni, set_pc_branch8, set_pc_branch16, set_pc_jmp,
        output up_ld8, up_ld16, stk_go, stk_dir,
        input  stk_done
    );

    modport ctrl (
        input ni, set_pc_branch8, set_pc_branch16, set_pc_jmp,
        input up_ld8, up_ld16
    );

    modport pshpul (
        input  stk_go, stk_dir,
        output stk_done
    );

endinterface
